// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = PathOramTb
FILELIST = sources.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Result: fail"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "Result: no verdict"; exit 1; fi
	@echo "Result: pass"

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== sources.f ====
verilog/OramPkg.sv
verilog/DramPkg.sv
verilog/PositionMap.sv
verilog/PathStash.sv
verilog/PathBackend.sv
verilog/BucketWhitener.sv
verilog/PathOramTop.sv
tests/PathOramProps.sv
tests/PathOramTb.sv

// ==== tests/PathOramProps.sv ====
//--------------------------------------------------------------------------
// Assertions on the backend memory port and stash, bound to PathBackend
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module PathOramProps (
	input logic Clock,
	input logic rst,
	input DramPkg::dramCmdT DramCmd,
	input logic DramCmdValid,
	input logic DramCmdReady,
	input logic InitDone,
	input logic Overflow
);

	// Stash must always have room
	stashNoOverflow: assert property (@(posedge Clock) disable iff (rst) !Overflow)
		else $error("Stash overflow in the backend");

	// Stalled command holds still until taken
	cmdStableWhileStalled: assert property (@(posedge Clock) disable iff (rst)
		DramCmdValid && !DramCmdReady |=> DramCmdValid && $stable(DramCmd))
		else $error("Memory command changed while stalled");

	// Only the clearing writes run before init is done
	noReadBeforeInit: assert property (@(posedge Clock) disable iff (rst)
		DramCmdValid && !InitDone |-> DramCmd.op == DramPkg::DramWrite)
		else $error("Memory read issued before InitDone");

endmodule

bind PathBackend PathOramProps props (
	.Clock(Clock),
	.rst(rst),
	.DramCmd(DramCmd),
	.DramCmdValid(DramCmdValid),
	.DramCmdReady(DramCmdReady),
	.InitDone(InitDone),
	.Overflow(stashOverflow)
);

// ==== tests/PathOramTb.sv ====
//--------------------------------------------------------------------------
// Testbench for the Path ORAM top level with a stalling bucket memory model
// Replays tests/oram_stim.txt and checks read data and per-access path traffic
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module PathOramTb;

	localparam int MaxLines = 64;
	localparam int PathLen = OramPkg::TreeLevels;

	logic Clock;
	logic rst;
	OramPkg::userCmdT Cmd;
	logic CmdValid;
	logic CmdReady;
	OramPkg::dataT DataOut;
	logic DataOutValid;
	logic DataOutReady;
	DramPkg::dramCmdT DramCmd;
	logic DramCmdValid;
	logic DramCmdReady;
	DramPkg::wordT DramReadData;
	logic DramReadValid;

	// Separate streams for memory stalls and output stalls
	int dramSeed = 35;
	int outSeed = 35;
	int cycles = 0;
	int cycleLimit = 400 * MaxLines + 200;
	int numLines;
	int initWrites;
	logic [OramPkg::BucketCount-1:0] initSeen;
	// Four words per line for op, addr, write data and expected
	logic [31:0] stimMem [4*MaxLines];
	DramPkg::wordT memory [OramPkg::BucketCount];
	DramPkg::indexT retIdx [$];
	int retDue [$];
	// Memory commands seen during the current access
	DramPkg::dramOpT traceOp [$];
	DramPkg::indexT traceIdx [$];

	PathOramTop #(
		.StashCapacity(8),
		.WhitenKey(32'h5A17C3E9),
		.LfsrSeed(16'hACE1)
	) DUT (
		.Clock(Clock),
		.rst(rst),
		.Cmd(Cmd),
		.CmdValid(CmdValid),
		.CmdReady(CmdReady),
		.DataOut(DataOut),
		.DataOutValid(DataOutValid),
		.DataOutReady(DataOutReady),
		.DramCmd(DramCmd),
		.DramCmdValid(DramCmdValid),
		.DramCmdReady(DramCmdReady),
		.DramReadData(DramReadData),
		.DramReadValid(DramReadValid)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	//----------------------------------------------------------------------
	// Failure reporting and compares
	//----------------------------------------------------------------------

	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic compareData(string name, OramPkg::dataT got, OramPkg::dataT exp);
		if (got !== exp)
			abortRun($sformatf("Fail t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic compareIndex(string name, DramPkg::indexT got, DramPkg::indexT exp);
		if (got !== exp)
			abortRun($sformatf("Fail t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic compareOp(string name, DramPkg::dramOpT got, DramPkg::dramOpT exp);
		if (got !== exp)
			abortRun($sformatf("Fail t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic compareCount(string name, int got, int exp);
		if (got != exp)
			abortRun($sformatf("Fail t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	//----------------------------------------------------------------------
	// Memory model
	//----------------------------------------------------------------------

	task automatic acceptCommand();
		DramPkg::indexT idx;
		idx = DramCmd.bucket;
		if (int'(idx) >= OramPkg::BucketCount) begin
			abortRun($sformatf("Memory command to bucket %0d, outside the tree", idx));
		end else if (initWrites < OramPkg::BucketCount && DramCmd.op != DramPkg::DramWrite) begin
			abortRun("Memory read issued before the init sweep finished");
		end else if (initWrites < OramPkg::BucketCount && initSeen[idx]) begin
			abortRun($sformatf("Bucket %0d cleared twice during init", idx));
		end else if (initWrites < OramPkg::BucketCount && DramCmd.wdata == '0) begin
			// Empty buckets must reach memory whitened
			abortRun($sformatf("Init write to bucket %0d is an empty bucket left in the clear",
				idx));
		end else begin
			if (initWrites < OramPkg::BucketCount) begin
				initSeen[idx] = 1'b1;
				initWrites++;
			end else begin
				traceOp.push_back(DramCmd.op);
				traceIdx.push_back(idx);
			end
			if (DramCmd.op == DramPkg::DramWrite) begin
				memory[idx] = DramCmd.wdata;
			end else begin
				retIdx.push_back(idx);
				retDue.push_back(cycles + 2);
			end
		end
	endtask

	task automatic serveMemory();
		DramPkg::indexT idx;
		DramReadValid = 1'b0;
		// Reads come back in order with one strobe each
		if (retDue.size() > 0 && retDue[0] == cycles) begin
			idx = retIdx.pop_front();
			void'(retDue.pop_front());
			DramReadValid = 1'b1;
			DramReadData = memory[idx];
		end
		if (rst) begin
			DramCmdReady = 1'b0;
		end else begin
			// Ready about three cycles in four
			DramCmdReady = ($random(dramSeed) & 3) != 0;
			if (DramCmdValid && DramCmdReady)
				acceptCommand();
		end
	endtask

	initial begin : memoryModel
		DramCmdReady = 1'b0;
		DramReadValid = 1'b0;
		DramReadData = '0;
		initWrites = 0;
		initSeen = '0;
		for (int i = 0; i < OramPkg::BucketCount; i++)
			memory[i] = {20{4'(i)}};
		forever begin
			@(negedge Clock);
			if (CmdReady && initWrites < OramPkg::BucketCount)
				abortRun("CmdReady went high before all init writes were seen");
			else
				serveMemory();
		end
	end

	//----------------------------------------------------------------------
	// Access checks
	//----------------------------------------------------------------------

	// Reads go root to leaf and writes retrace the same path back up
	task automatic checkPathTrace(int line);
		string tag;
		int parent;
		tag = $sformatf(" on line %0d", line);
		compareCount({"memory commands", tag}, traceOp.size(), 2 * PathLen);
		compareIndex({"DramCmd.bucket of root read", tag}, traceIdx[0], '0);
		for (int k = 0; k < PathLen; k++) begin
			compareOp({"DramCmd.op of path read", tag}, traceOp[k], DramPkg::DramRead);
			compareOp({"DramCmd.op of writeback", tag}, traceOp[PathLen+k], DramPkg::DramWrite);
			compareIndex({"DramCmd.bucket of writeback", tag}, traceIdx[PathLen+k],
				traceIdx[PathLen-1-k]);
		end
		for (int k = 1; k < PathLen; k++) begin
			parent = int'(traceIdx[k-1]);
			if (int'(traceIdx[k]) != 2 * parent + 1 && int'(traceIdx[k]) != 2 * parent + 2)
				abortRun($sformatf("Bucket %0d read at level %0d is not a child of bucket %0d%s",
					traceIdx[k], k, parent, tag));
		end
	endtask

	task automatic runAccess(int line, logic write, OramPkg::addrT addr,
		OramPkg::dataT wdata, OramPkg::dataT expected);
		OramPkg::userCmdT cmd;
		while (!CmdReady)
			@(negedge Clock);
		cmd.write = write;
		cmd.addr = addr;
		cmd.data = wdata;
		traceOp.delete();
		traceIdx.delete();
		Cmd = cmd;
		CmdValid = 1'b1;
		@(negedge Clock);
		CmdValid = 1'b0;
		Cmd = '0;
		if (write) begin
			// Write is over once a new command can go in
			while (!CmdReady)
				@(negedge Clock);
			checkPathTrace(line);
		end else begin
			while (!DataOutValid)
				@(negedge Clock);
			checkPathTrace(line);
			// Hold the word back for a random stretch
			DataOutReady = ($random(outSeed) & 1) != 0;
			while (!DataOutReady) begin
				@(negedge Clock);
				if (!DataOutValid)
					abortRun($sformatf("DataOutValid dropped while held on line %0d", line));
				compareData("DataOut", DataOut, expected);
				DataOutReady = ($random(outSeed) & 1) != 0;
			end
			compareData("DataOut", DataOut, expected);
			@(negedge Clock);
			DataOutReady = 1'b0;
		end
	endtask

	//----------------------------------------------------------------------
	// Stimulus and watchdog
	//----------------------------------------------------------------------

	initial begin : stimulus
		int line;
		rst = 1'b1;
		Cmd = '0;
		CmdValid = 1'b0;
		DataOutReady = 1'b0;
		// Op column above 1 marks the end of the file
		for (int i = 0; i < 4 * MaxLines; i++)
			stimMem[i] = 32'hFFFF0000 | 32'(i);
		$readmemh("tests/oram_stim.txt", stimMem);
		numLines = 0;
		while (numLines < MaxLines && stimMem[4*numLines] <= 32'd1)
			numLines++;
		cycleLimit = 400 * numLines + 200;
		repeat (3) @(posedge Clock);
		@(negedge Clock);
		rst = 1'b0;
		for (line = 0; line < numLines; line++)
			runAccess(line + 1, stimMem[4*line][0], OramPkg::addrT'(stimMem[4*line+1]),
				stimMem[4*line+2], stimMem[4*line+3]);
		@(negedge Clock);
		if (numLines > 0 && initWrites == OramPkg::BucketCount) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			abortRun("Stim file empty or init sweep never completed");
		end
	end

	initial begin : watchdog
		while (cycles <= cycleLimit) begin
			@(posedge Clock);
			cycles++;
		end
		abortRun($sformatf("Timeout after %0d cycles, DUT stopped responding", cycles));
	end

endmodule

// ==== tests/oram_stim.txt ====
// op addr wdata expected, hex; op 1 is a write, 0 a read
// expected is checked on reads only, zero for never-written blocks
0 5 00000000 00000000
1 0 A5A50000 00000000
1 1 0BADBEEF 00000000
0 0 00000000 A5A50000
1 2 12345678 00000000
1 7 CAFEF00D 00000000
0 1 00000000 0BADBEEF
0 9 00000000 00000000
1 C 00C0FFEE 00000000
0 2 00000000 12345678
0 7 00000000 CAFEF00D
1 0 DEADBEEF 00000000
0 F 00000000 00000000
0 0 00000000 DEADBEEF
0 C 00000000 00C0FFEE
1 5 55555555 00000000
1 9 99990009 00000000
0 5 00000000 55555555
0 1 00000000 0BADBEEF
1 F FFFF0001 00000000
0 9 00000000 99990009
0 2 00000000 12345678
1 2 22220002 00000000
0 7 00000000 CAFEF00D
0 F 00000000 FFFF0001
0 2 00000000 22220002
0 0 00000000 DEADBEEF
1 1 10101010 00000000
0 C 00000000 00C0FFEE
0 1 00000000 10101010
1 7 77777777 00000000
0 5 00000000 55555555
0 7 00000000 77777777
1 C 00000000 00000000
0 C 00000000 00000000
0 9 00000000 99990009
0 F 00000000 FFFF0001
0 0 00000000 DEADBEEF

// ==== verilog/BucketWhitener.sv ====
//--------------------------------------------------------------------------
// Keystream XOR between backend and external memory
// Write words are whitened by their own bucket index, read words by the
// index of the oldest outstanding read
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module BucketWhitener #(
	parameter logic [31:0] WhitenKey = 32'h5A17C3E9
) (
	input  logic Clock,
	input  logic rst,
	input  DramPkg::dramCmdT DramCmdIn,
	input  logic DramCmdValid,
	input  logic DramCmdReady,
	output DramPkg::dramCmdT DramCmdOut,
	input  DramPkg::wordT ReadIn,
	input  logic DramReadValid,
	output DramPkg::wordT ReadOut
);

	DramPkg::indexT idxQueue [4];
	logic [1:0] head;
	logic [1:0] tail;
	logic pushRead;

	// Mix key and index, then stretch over one bucket word
	function automatic DramPkg::wordT keystream(DramPkg::indexT idx);
		logic [31:0] mix;
		logic [95:0] stream;
		mix = WhitenKey ^ (32'(idx) * 32'h9E3779B9);
		for (int i = 0; i < 3; i++) begin
			mix = {mix[24:0], mix[31:25]} ^ (mix >> 3) ^ 32'h7F4A7C15;
			stream[i*32 +: 32] = mix;
		end
		return stream[DramPkg::WordBits-1:0];
	endfunction

	assign pushRead = DramCmdValid && DramCmdReady && (DramCmdIn.op == DramPkg::DramRead);

	// Read index queue
	always_ff @(posedge Clock) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (pushRead)
				tail <= tail + 1'b1;
			if (DramReadValid)
				head <= head + 1'b1;
		end
	end

	always_ff @(posedge Clock) begin
		if (pushRead)
			idxQueue[tail] <= DramCmdIn.bucket;
	end

	always_comb begin
		DramCmdOut = DramCmdIn;
		if (DramCmdIn.op == DramPkg::DramWrite)
			DramCmdOut.wdata = DramCmdIn.wdata ^ keystream(DramCmdIn.bucket);
	end

	assign ReadOut = ReadIn ^ keystream(idxQueue[head]);

endmodule

// ==== verilog/DramPkg.sv ====
//--------------------------------------------------------------------------
// External memory command and word types
// One memory word carries exactly one bucket
//--------------------------------------------------------------------------
package DramPkg;

	localparam int IndexBits = 4;
	localparam int WordBits = $bits(OramPkg::bucketT);

	typedef logic [IndexBits-1:0] indexT;
	typedef logic [WordBits-1:0] wordT;

	typedef enum logic {DramRead = 1'b0, DramWrite = 1'b1} dramOpT;

	// Write word is ignored on reads
	typedef struct packed {dramOpT op; indexT bucket; wordT wdata;} dramCmdT;

endpackage

// ==== verilog/OramPkg.sv ====
//--------------------------------------------------------------------------
// Tree geometry and block types shared by the ORAM front end and backend
// Fixed sizes, so every module sees the same bucket and block layout
//--------------------------------------------------------------------------
package OramPkg;

	// Tree shape
	localparam int TreeLevels = 4;
	localparam int LeafBits = TreeLevels - 1;
	localparam int BucketCount = (1 << TreeLevels) - 1;
	localparam int SlotsPerBucket = 2;
	localparam int LevelBits = 2;

	// Client block space
	localparam int AddrBits = 4;
	localparam int DataBits = 32;

	typedef logic [AddrBits-1:0] addrT;
	typedef logic [LeafBits-1:0] leafT;
	typedef logic [LevelBits-1:0] levelT;
	typedef logic [DataBits-1:0] dataT;

	// One block slot, 40 bits
	typedef struct packed {logic valid; addrT addr; leafT leaf; dataT data;} blockT;

	// Slot 0 sits in the low bits
	typedef struct packed {blockT [SlotsPerBucket-1:0] slots;} bucketT;

	typedef struct packed {logic write; addrT addr; dataT data;} userCmdT;

	// Request plus both leaves, as handed to the backend
	typedef struct packed {
		logic write;
		addrT addr;
		dataT data;
		leafT oldLeaf;
		leafT newLeaf;
	} backendCmdT;

endpackage

// ==== verilog/PathBackend.sv ====
//--------------------------------------------------------------------------
// Path ORAM backend sequencer
// Clears the tree, then per access reads a path, serves it, writes it back
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module PathBackend #(
	parameter int StashCapacity = 8
) (
	input  logic Clock,
	input  logic rst,
	input  OramPkg::backendCmdT BeCmd,
	input  logic BeCmdValid,
	output logic BeCmdReady,
	output OramPkg::dataT BeReadData,
	output logic BeReadValid,
	input  logic BeReadReady,
	output DramPkg::dramCmdT DramCmd,
	output logic DramCmdValid,
	input  logic DramCmdReady,
	input  OramPkg::bucketT DramReadData,
	input  logic DramReadValid,
	output logic InitDone
);

	typedef enum logic [2:0] {
		StBoot, StInit, StIdle, StRead, StAbsorb, StServe, StWrite, StDone
	} stateT;

	stateT state;
	OramPkg::backendCmdT cmdReg;
	// Init bucket, read issue level or absorb slot, by state
	logic [3:0] count;
	logic [2:0] rdCount;
	OramPkg::levelT wrLevel;
	// 0 and 1 fill slots, 2 issues the bucket
	logic [1:0] wrSlot;
	OramPkg::bucketT pathBuf [OramPkg::TreeLevels];
	OramPkg::bucketT wrBucket;
	OramPkg::dataT readVal;

	OramPkg::blockT insertBlock;
	OramPkg::blockT foundBlock;
	OramPkg::blockT updateBlock;
	OramPkg::blockT evictBlock;
	logic found;
	logic evictValid;
	logic evictTake;
	logic stashOverflow;

	// Heap index of the bucket at lvl on the path to leaf
	function automatic DramPkg::indexT pathIndex(OramPkg::leafT leaf, OramPkg::levelT lvl);
		int node;
		node = (1 << lvl) - 1 + (int'(leaf) >> (OramPkg::LeafBits - int'(lvl)));
		return DramPkg::indexT'(node);
	endfunction

	assign BeCmdReady = (state == StIdle);
	assign BeReadValid = (state == StDone);
	assign BeReadData = readVal;

	//----------------------------------------------------------------------
	// Stash
	//----------------------------------------------------------------------

	assign insertBlock = pathBuf[count[2:1]].slots[count[0]];
	assign evictTake = (state == StWrite) && (wrSlot != 2'd2) && evictValid;

	// Served block moves to its new leaf
	always_comb begin
		updateBlock.valid = 1'b1;
		updateBlock.addr = cmdReg.addr;
		updateBlock.leaf = cmdReg.newLeaf;
		updateBlock.data = cmdReg.write ? cmdReg.data : (found ? foundBlock.data : '0);
	end

	PathStash #(
		.StashCapacity(StashCapacity)
	) stash (
		.Clock(Clock),
		.rst(rst),
		.Insert(insertBlock),
		.InsertValid(state == StAbsorb),
		.Lookup(cmdReg.addr),
		.Found(found),
		.FoundBlock(foundBlock),
		.Update(updateBlock),
		.UpdateValid(state == StServe),
		.EvictLeaf(cmdReg.oldLeaf),
		.EvictLevel(wrLevel),
		.EvictTake(evictTake),
		.EvictBlock(evictBlock),
		.EvictValid(evictValid),
		.Overflow(stashOverflow)
	);

	//----------------------------------------------------------------------
	// Memory command
	//----------------------------------------------------------------------

	// Driven from registers only, so it holds while stalled
	always_comb begin
		DramCmd = '0;
		DramCmdValid = 1'b0;
		case (state)
			StInit: begin
				DramCmdValid = 1'b1;
				DramCmd.op = DramPkg::DramWrite;
				DramCmd.bucket = count;
			end
			StRead: begin
				DramCmdValid = (count < OramPkg::TreeLevels);
				DramCmd.bucket = pathIndex(cmdReg.oldLeaf, OramPkg::levelT'(count));
			end
			StWrite: begin
				DramCmdValid = (wrSlot == 2'd2);
				DramCmd.op = DramPkg::DramWrite;
				DramCmd.bucket = pathIndex(cmdReg.oldLeaf, wrLevel);
				DramCmd.wdata = wrBucket;
			end
			default: ;
		endcase
	end

	//----------------------------------------------------------------------
	// Sequencer
	//----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if ((state == StIdle) && BeCmdValid)
			cmdReg <= BeCmd;
		// Memory returns in command order, root first
		if ((state == StRead) && DramReadValid)
			pathBuf[rdCount[1:0]] <= DramReadData;
		if (state == StServe)
			readVal <= found ? foundBlock.data : '0;
		if ((state == StWrite) && (wrSlot != 2'd2))
			wrBucket.slots[wrSlot[0]] <= evictValid ? evictBlock : '0;
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= StBoot;
			count <= '0;
			rdCount <= '0;
			wrLevel <= '0;
			wrSlot <= '0;
			InitDone <= 1'b0;
		end else begin
			case (state)
				StBoot: state <= StInit;
				// Write every bucket empty
				StInit: if (DramCmdReady) begin
					count <= count + 1'b1;
					if (count == 4'(OramPkg::BucketCount - 1)) begin
						state <= StIdle;
						InitDone <= 1'b1;
					end
				end
				StIdle: if (BeCmdValid) begin
					count <= '0;
					rdCount <= '0;
					state <= StRead;
				end
				StRead: begin
					if (DramCmdValid && DramCmdReady)
						count <= count + 1'b1;
					if (DramReadValid)
						rdCount <= rdCount + 1'b1;
					if (rdCount == 3'(OramPkg::TreeLevels)) begin
						count <= '0;
						state <= StAbsorb;
					end
				end
				StAbsorb: begin
					count <= count + 1'b1;
					if (count == 4'(OramPkg::TreeLevels * OramPkg::SlotsPerBucket - 1))
						state <= StServe;
				end
				StServe: begin
					wrLevel <= OramPkg::levelT'(OramPkg::TreeLevels - 1);
					wrSlot <= '0;
					state <= StWrite;
				end
				// Leaf to root
				StWrite: if (wrSlot != 2'd2) begin
					wrSlot <= wrSlot + 1'b1;
				end else if (DramCmdReady) begin
					wrSlot <= '0;
					wrLevel <= wrLevel - 1'b1;
					if (wrLevel == '0)
						state <= StDone;
				end
				StDone: if (BeReadReady) state <= StIdle;
				default: state <= StIdle;
			endcase
		end
	end

endmodule

// ==== verilog/PathOramTop.sv ====
//--------------------------------------------------------------------------
// Path ORAM controller top level
// User command port on one side, whitened bucket memory port on the other
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module PathOramTop #(
	parameter int StashCapacity = 8,
	parameter logic [31:0] WhitenKey = 32'h5A17C3E9,
	parameter logic [15:0] LfsrSeed = 16'hACE1
) (
	input  logic Clock,
	input  logic rst,
	input  OramPkg::userCmdT Cmd,
	input  logic CmdValid,
	output logic CmdReady,
	output OramPkg::dataT DataOut,
	output logic DataOutValid,
	input  logic DataOutReady,
	output DramPkg::dramCmdT DramCmd,
	output logic DramCmdValid,
	input  logic DramCmdReady,
	input  DramPkg::wordT DramReadData,
	input  logic DramReadValid
);

	//----------------------------------------------------------------------
	// Front end to backend
	//----------------------------------------------------------------------

	OramPkg::backendCmdT beCmd;
	logic beCmdValid;
	logic beCmdReady;
	OramPkg::dataT beReadData;
	logic beReadValid;
	logic beReadReady;
	logic initDone;

	// Backend side of the whitener, in the clear
	DramPkg::dramCmdT plainCmd;
	DramPkg::wordT plainRead;

	PositionMap #(
		.LfsrSeed(LfsrSeed)
	) frontEnd (
		.Clock(Clock),
		.rst(rst),
		.Cmd(Cmd),
		.CmdValid(CmdValid),
		.CmdReady(CmdReady),
		.DataOut(DataOut),
		.DataOutValid(DataOutValid),
		.DataOutReady(DataOutReady),
		.BeCmd(beCmd),
		.BeCmdValid(beCmdValid),
		.BeCmdReady(beCmdReady),
		.BeReadData(beReadData),
		.BeReadValid(beReadValid),
		.BeReadReady(beReadReady),
		.InitDone(initDone)
	);

	// Handshakes go straight to memory, only payloads are whitened
	PathBackend #(
		.StashCapacity(StashCapacity)
	) backEnd (
		.Clock(Clock),
		.rst(rst),
		.BeCmd(beCmd),
		.BeCmdValid(beCmdValid),
		.BeCmdReady(beCmdReady),
		.BeReadData(beReadData),
		.BeReadValid(beReadValid),
		.BeReadReady(beReadReady),
		.DramCmd(plainCmd),
		.DramCmdValid(DramCmdValid),
		.DramCmdReady(DramCmdReady),
		.DramReadData(plainRead),
		.DramReadValid(DramReadValid),
		.InitDone(initDone)
	);

	BucketWhitener #(
		.WhitenKey(WhitenKey)
	) whitener (
		.Clock(Clock),
		.rst(rst),
		.DramCmdIn(plainCmd),
		.DramCmdValid(DramCmdValid),
		.DramCmdReady(DramCmdReady),
		.DramCmdOut(DramCmd),
		.ReadIn(DramReadData),
		.DramReadValid(DramReadValid),
		.ReadOut(plainRead)
	);

endmodule

// ==== verilog/PathStash.sv ====
//--------------------------------------------------------------------------
// Stash of blocks pulled off the current path
// Holds blocks between path read and writeback, picks blocks for eviction
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module PathStash #(
	parameter int StashCapacity = 8
) (
	input  logic Clock,
	input  logic rst,
	input  OramPkg::blockT Insert,
	input  logic InsertValid,
	input  OramPkg::addrT Lookup,
	output logic Found,
	output OramPkg::blockT FoundBlock,
	input  OramPkg::blockT Update,
	input  logic UpdateValid,
	input  OramPkg::leafT EvictLeaf,
	input  OramPkg::levelT EvictLevel,
	input  logic EvictTake,
	output OramPkg::blockT EvictBlock,
	output logic EvictValid,
	output logic Overflow
);

	localparam int IdxBits = (StashCapacity > 1) ? $clog2(StashCapacity) : 1;

	OramPkg::blockT entries [StashCapacity];

	logic freeFound;
	logic updFound;
	logic [IdxBits-1:0] freeIdx;
	logic [IdxBits-1:0] updIdx;
	logic [IdxBits-1:0] evictIdx;

	// True when both leaves share the path from root down to lvl
	function automatic logic onPath(OramPkg::leafT a, OramPkg::leafT b, OramPkg::levelT lvl);
		int shift;
		shift = OramPkg::LeafBits - int'(lvl);
		return (a >> shift) == (b >> shift);
	endfunction

	//----------------------------------------------------------------------
	// Search
	//----------------------------------------------------------------------

	// Walk downward so the lowest matching index wins
	always_comb begin
		freeFound = 1'b0;
		freeIdx = '0;
		updFound = 1'b0;
		updIdx = '0;
		Found = 1'b0;
		FoundBlock = '0;
		EvictValid = 1'b0;
		evictIdx = '0;
		for (int i = StashCapacity - 1; i >= 0; i--) begin
			if (!entries[i].valid) begin
				freeFound = 1'b1;
				freeIdx = IdxBits'(i);
			end else begin
				if (entries[i].addr == Lookup) begin
					Found = 1'b1;
					FoundBlock = entries[i];
				end
				if (entries[i].addr == Update.addr) begin
					updFound = 1'b1;
					updIdx = IdxBits'(i);
				end
				// Eviction candidate for the bucket at EvictLevel
				if (onPath(entries[i].leaf, EvictLeaf, EvictLevel)) begin
					EvictValid = 1'b1;
					evictIdx = IdxBits'(i);
				end
			end
		end
	end

	assign EvictBlock = entries[evictIdx];

	// No room for a new block
	assign Overflow = (InsertValid && Insert.valid && !freeFound) ||
		(UpdateValid && !updFound && !freeFound);

	//----------------------------------------------------------------------
	// Storage
	//----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int i = 0; i < StashCapacity; i++)
				entries[i].valid <= 1'b0;
		end else if (InsertValid) begin
			// Empty path slots are dropped here
			if (Insert.valid && freeFound)
				entries[freeIdx] <= Insert;
		end else if (UpdateValid) begin
			if (updFound)
				entries[updIdx] <= Update;
			else if (freeFound)
				entries[freeIdx] <= Update;
		end else if (EvictTake && EvictValid) begin
			entries[evictIdx].valid <= 1'b0;
		end
	end

endmodule

// ==== verilog/PositionMap.sv ====
//--------------------------------------------------------------------------
// ORAM front end with on-chip position map and LFSR leaf remapping
// Accepts one user command at a time and forwards it to the backend
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module PositionMap #(
	parameter logic [15:0] LfsrSeed = 16'hACE1
) (
	input  logic Clock,
	input  logic rst,
	input  OramPkg::userCmdT Cmd,
	input  logic CmdValid,
	output logic CmdReady,
	output OramPkg::dataT DataOut,
	output logic DataOutValid,
	input  logic DataOutReady,
	output OramPkg::backendCmdT BeCmd,
	output logic BeCmdValid,
	input  logic BeCmdReady,
	input  OramPkg::dataT BeReadData,
	input  logic BeReadValid,
	output logic BeReadReady,
	input  logic InitDone
);

	typedef enum logic [2:0] {PmSweep, PmIdle, PmIssue, PmWait, PmRespond} stateT;

	stateT state;
	logic [15:0] lfsr;
	logic lfsrStep;
	logic accept;
	OramPkg::addrT sweepIdx;
	OramPkg::leafT newLeaf;
	// Leaf per block, filled by the sweep
	OramPkg::leafT leafMap [1 << OramPkg::AddrBits];

	assign CmdReady = (state == PmIdle) && InitDone;
	assign accept = CmdValid && CmdReady;
	assign BeCmdValid = (state == PmIssue);
	assign BeReadReady = (state == PmWait);
	assign DataOutValid = (state == PmRespond);
	assign newLeaf = lfsr[OramPkg::LeafBits-1:0];
	// Advance once per sweep entry and once per access
	assign lfsrStep = (state == PmSweep) || accept;

	// x^16 + x^14 + x^13 + x^11 + 1
	always_ff @(posedge Clock) begin
		if (rst)
			lfsr <= LfsrSeed;
		else if (lfsrStep)
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	always_ff @(posedge Clock) begin
		if (state == PmSweep)
			leafMap[sweepIdx] <= newLeaf;
		else if (accept)
			leafMap[Cmd.addr] <= newLeaf;
	end

	// Old leaf is read in the same edge that stores the new one
	always_ff @(posedge Clock) begin
		if (accept)
			BeCmd <= '{write: Cmd.write, addr: Cmd.addr, data: Cmd.data,
				oldLeaf: leafMap[Cmd.addr], newLeaf: newLeaf};
		if ((state == PmWait) && BeReadValid)
			DataOut <= BeReadData;
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= PmSweep;
			sweepIdx <= '0;
		end else begin
			case (state)
				PmSweep: begin
					sweepIdx <= sweepIdx + 1'b1;
					if (sweepIdx == '1)
						state <= PmIdle;
				end
				PmIdle: if (accept) state <= PmIssue;
				PmIssue: if (BeCmdReady) state <= PmWait;
				// Writes finish here, reads still owe the user a word
				PmWait: if (BeReadValid) state <= BeCmd.write ? PmIdle : PmRespond;
				PmRespond: if (DataOutReady) state <= PmIdle;
				default: state <= PmIdle;
			endcase
		end
	end

endmodule
